// ==== filelist.f ====
+incdir+logic
logic/replica_pkg.sv
logic/city_counter.sv
logic/tour_sequencer.sv
logic/tour_length_accum.sv
logic/tour_buffer.sv
logic/best_tour_keeper.sv
logic/best_tour_tracker.sv
dv/best_tour_tracker_properties.sv
dv/best_tour_tracker_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the best tour tracker testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f filelist.f \
        --top-module best_tour_tracker_tb -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vbest_tour_tracker_tb 2>&1)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -q "^Test passed$"; then
    exit 0
fi
exit 1

// ==== dv/best_tour_tracker_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "replica_consts.svh"

module best_tour_tracker_tb
    import replica_pkg::*;
();

    localparam int MAX_GAP     = 3;
    localparam int NUM_TOURS   = 10;
    localparam int READ_CYCLES = 80;
    localparam int WATCHDOG_CYCLES =
        2 * (32 + NUM_TOURS * (`CITY_COUNT * (MAX_GAP + 1) + 10) + READ_CYCLES);

    logic          clk;
    logic          reset;
    logic          coord_wr;
    city_t         coord_addr;
    coord_t        coord_x;
    coord_t        coord_y;
    logic          tour_valid;
    logic          tour_ready;
    city_t         tour_city;
    total_data_t   tour_distance;
    logic          tour_distance_valid;
    total_data_t   best_distance;
    logic          read_restart;
    logic          min_ord_read;
    logic          ordering_min_valid;
    replica_data_t ordering_min_data;

    logic [31:0] rng;
    int          exp_best;
    city_t       rd_ptr;                      // expected read pointer.
    coord_t      cx [0:`CITY_COUNT-1];
    coord_t      cy [0:`CITY_COUNT-1];
    city_t       cand [0:`CITY_COUNT-1];      // tour about to be sent.
    city_t       best_order [0:`CITY_COUNT-1];

    best_tour_tracker u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Error: the run timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        wait (u_dut.u_properties.assert_fails != 0);
        $display("Error: a bound assertion failed");
        $display("Test failed");
        $fatal(1, "assertion failure seen");
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_below(input int unsigned n);
        rng = xorshift(rng);
        return rng % n;
    endfunction

    // closed manhattan length, last city back to the first.
    function automatic int tour_length_model(input city_t t [0:`CITY_COUNT-1]);
        int    total;
        int    i;
        int    dx;
        int    dy;
        city_t a;
        city_t b;
        total = 0;
        for (i = 0; i < `CITY_COUNT; i++) begin
            a = t[city_t'(i)];
            b = t[city_t'(i + 1)]; // wraps to entry 0.
            dx = int'(cx[a]) - int'(cx[b]);
            dy = int'(cy[a]) - int'(cy[b]);
            total += ((dx < 0) ? -dx : dx) + ((dy < 0) ? -dy : dy);
        end
        return total;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected %0d, actual %0d", name, expected, actual);
            $display("Test failed");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic make_perm();
        int    i;
        int    j;
        city_t tmp;
        for (i = 0; i < `CITY_COUNT; i++) begin
            cand[city_t'(i)] = city_t'(i);
        end
        for (i = `CITY_COUNT - 1; i > 0; i--) begin
            j = int'(rand_below(i + 1));
            tmp = cand[city_t'(i)];
            cand[city_t'(i)] = cand[city_t'(j)];
            cand[city_t'(j)] = tmp;
        end
    endtask

    // want 0 any, 1 longer than best, 2 shorter than best.
    task automatic pick_tour(input int want);
        int tries;
        int len;
        tries = 0;
        make_perm();
        len = tour_length_model(cand);
        while ((want == 1 && len <= exp_best) || (want == 2 && len >= exp_best)) begin
            tries++;
            if (tries > 2000) begin
                $display("Error: no random tour of the required length was found");
                $display("Test failed");
                $fatal(1, "tour search exhausted");
            end
            make_perm();
            len = tour_length_model(cand);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_coords();
        int i;
        for (i = 0; i < `CITY_COUNT; i++) begin
            cx[city_t'(i)] = coord_t'(rand_below(256));
            cy[city_t'(i)] = coord_t'(rand_below(256));
            coord_wr   = 1'b1;
            coord_addr = city_t'(i);
            coord_x    = cx[city_t'(i)];
            coord_y    = cy[city_t'(i)];
            @(posedge clk);
            #1;
        end
        coord_wr = 1'b0;
    endtask

    task automatic send_tour(input string name, input int max_gap);
        int i;
        int gap;
        int len;
        int low_cycles;
        int pulses;
        len = tour_length_model(cand);
        for (i = 0; i < `CITY_COUNT; i++) begin
            gap = int'(rand_below(max_gap + 1));
            tour_valid = 1'b0;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            tour_valid = 1'b1;
            tour_city  = cand[city_t'(i)];
            while (!tour_ready) begin
                @(posedge clk);
                #1;
            end
            @(posedge clk); // city taken here.
            #1;
        end
        tour_valid = 1'b0;
        tour_city  = '0;
        low_cycles = 0;
        pulses     = 0;
        while (!tour_ready) begin
            if (tour_distance_valid) begin
                pulses++;
                check_value({name, " distance"}, len, 32'(tour_distance));
            end
            low_cycles++;
            @(posedge clk);
            #1;
        end
        check_value({name, " distance pulses"}, 1, pulses);
        check_value({name, " busy cycles"}, 10, low_cycles);
        if (len < exp_best) begin
            exp_best   = len;
            best_order = cand;
        end
        check_value({name, " best"}, exp_best, 32'(best_distance));
    endtask

    task automatic read_best(input string name, input int count);
        int k;
        for (k = 0; k < count; k++) begin
            min_ord_read = 1'b1;
            @(posedge clk);
            #1;
            check_value({name, " read valid"}, 1, 32'(ordering_min_valid));
            check_value({name, " read data"}, 32'(best_order[rd_ptr]),
                        32'(ordering_min_data));
            rd_ptr = rd_ptr + city_t'(1);
        end
        min_ord_read = 1'b0;
        @(posedge clk);
        #1;
        check_value({name, " read idle"}, 0, 32'(ordering_min_valid));
    endtask

    task automatic restart_read();
        read_restart = 1'b1;
        @(posedge clk);
        #1;
        read_restart = 1'b0;
        rd_ptr       = '0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        rng          = 32'd46609;
        exp_best     = 32'hffff;
        rd_ptr       = '0;
        reset        = 1'b1;
        coord_wr     = 1'b0;
        coord_addr   = '0;
        coord_x      = '0;
        coord_y      = '0;
        tour_valid   = 1'b0;
        tour_city    = '0;
        read_restart = 1'b0;
        min_ord_read = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        check_value("reset best", 32'hffff, 32'(best_distance));
        check_value("reset ready", 1, 32'(tour_ready));
        load_coords();

        pick_tour(0);
        send_tour("first_tour", 0);
        read_best("first_tour", `CITY_COUNT);

        pick_tour(1);
        send_tour("longer_tour", 0);
        read_best("longer_tour", `CITY_COUNT);

        pick_tour(2);
        send_tour("shorter_tour", 0);
        read_best("shorter_tour", `CITY_COUNT);

        // rotated best tour, same length.
        for (int i = 0; i < `CITY_COUNT; i++) begin
            cand[city_t'(i)] = best_order[city_t'(i + 1)];
        end
        send_tour("equal_tour", 0);
        read_best("equal_tour", `CITY_COUNT);

        for (int n = 0; n < 6; n++) begin
            pick_tour(0);
            send_tour($sformatf("gap_tour_%0d", n), MAX_GAP);
        end
        read_best("gap_tours", `CITY_COUNT);

        read_best("restart_head", 3);
        restart_read();
        read_best("restart_full", `CITY_COUNT);

        if (u_dut.u_properties.assert_fails == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "assertion failures seen");
        end
    end

endmodule

`default_nettype wire

// ==== dv/best_tour_tracker_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module best_tour_tracker_properties
    import replica_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        tour_valid,
    input logic        tour_ready,
    input logic        last_city,
    input logic        replay_valid,
    input logic        tour_distance_valid,
    input logic        min_ord_read,
    input logic        ordering_min_valid,
    input total_data_t best_distance
);

    int unsigned assert_fails;

    initial assert_fails = 0;

    ////////////////////////////////////////////////////////////////////////////
    // handshake
    ////////////////////////////////////////////////////////////////////////////

    a_ready_after_last: assert property (@(posedge clk) disable iff (reset)
        (tour_valid && tour_ready && last_city) |=> !tour_ready)
        else begin
            assert_fails++;
            $error("tour_ready high after the last city");
        end

    // ready comes back only after the last replay beat.
    a_ready_return: assert property (@(posedge clk) disable iff (reset)
        $rose(tour_ready) |-> $past(replay_valid && last_city))
        else begin
            assert_fails++;
            $error("tour_ready back before the replay ended");
        end

    a_distance_pulse: assert property (@(posedge clk) disable iff (reset)
        tour_distance_valid |=> !tour_distance_valid)
        else begin
            assert_fails++;
            $error("tour_distance_valid longer than one cycle");
        end

    ////////////////////////////////////////////////////////////////////////////
    // readout and minimum
    ////////////////////////////////////////////////////////////////////////////

    a_read_follow: assert property (@(posedge clk) disable iff (reset)
        min_ord_read |=> ordering_min_valid)
        else begin
            assert_fails++;
            $error("read not answered one cycle later");
        end

    a_read_idle: assert property (@(posedge clk) disable iff (reset)
        !min_ord_read |=> !ordering_min_valid)
        else begin
            assert_fails++;
            $error("ordering_min_valid without a read");
        end

    a_best_monotonic: assert property (@(posedge clk) disable iff (reset)
        best_distance <= $past(best_distance))
        else begin
            assert_fails++;
            $error("best_distance increased");
        end

endmodule

bind best_tour_tracker best_tour_tracker_properties u_properties (
    .clk                 (clk),
    .reset               (reset),
    .tour_valid          (tour_valid),
    .tour_ready          (tour_ready),
    .last_city           (last_city),
    .replay_valid        (replay_valid),
    .tour_distance_valid (tour_distance_valid),
    .min_ord_read        (min_ord_read),
    .ordering_min_valid  (ordering_min_valid),
    .best_distance       (best_distance)
);

`default_nettype wire

// ==== logic/best_tour_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module best_tour_tracker
    import replica_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          coord_wr,
    input  city_t         coord_addr,
    input  coord_t        coord_x,
    input  coord_t        coord_y,
    input  logic          tour_valid,
    output logic          tour_ready,
    input  city_t         tour_city,
    output total_data_t   tour_distance,
    output logic          tour_distance_valid,
    output total_data_t   best_distance,
    input  logic          read_restart,
    input  logic          min_ord_read,
    output logic          ordering_min_valid,
    output replica_data_t ordering_min_data
);

    logic          count_en;
    logic          count_clear;
    logic          load_accept;
    logic          update_strobe;
    logic          replay_valid;
    logic          last_city;
    city_t         city_idx;
    replica_data_t replay_data;

    ////////////////////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////////////////////

    city_counter u_city_counter (
        .clk         (clk),
        .reset       (reset),
        .count_en    (count_en),
        .count_clear (count_clear),
        .city_idx    (city_idx),
        .last_city   (last_city)
    );

    tour_sequencer u_tour_sequencer (
        .clk                 (clk),
        .reset               (reset),
        .tour_valid          (tour_valid),
        .tour_ready          (tour_ready),
        .last_city           (last_city),
        .count_en            (count_en),
        .count_clear         (count_clear),
        .load_accept         (load_accept),
        .update_strobe       (update_strobe),
        .replay_valid        (replay_valid),
        .tour_distance_valid (tour_distance_valid)
    );

    ////////////////////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////////////////////

    tour_length_accum u_tour_length_accum (
        .clk           (clk),
        .reset         (reset),
        .coord_wr      (coord_wr),
        .coord_addr    (coord_addr),
        .coord_x       (coord_x),
        .coord_y       (coord_y),
        .load_accept   (load_accept),
        .tour_city     (tour_city),
        .city_idx      (city_idx),
        .last_city     (last_city),
        .tour_distance (tour_distance)
    );

    tour_buffer u_tour_buffer (
        .clk         (clk),
        .load_accept (load_accept),
        .tour_city   (tour_city),
        .city_idx    (city_idx),
        .replay_data (replay_data)
    );

    best_tour_keeper u_best_tour_keeper (
        .clk                     (clk),
        .reset                   (reset),
        .update_minimum_distance (update_strobe),
        .minimum_distance        (tour_distance),
        .replay_valid            (replay_valid),
        .replay_data             (replay_data),
        .read_restart            (read_restart),
        .min_ord_read            (min_ord_read),
        .ordering_min_valid      (ordering_min_valid),
        .ordering_min_data       (ordering_min_data),
        .best_distance           (best_distance)
    );

endmodule

`default_nettype wire

// ==== logic/best_tour_keeper.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "replica_consts.svh"

module best_tour_keeper
    import replica_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          update_minimum_distance,
    input  total_data_t   minimum_distance,
    input  logic          replay_valid,
    input  replica_data_t replay_data,
    input  logic          read_restart,
    input  logic          min_ord_read,
    output logic          ordering_min_valid,
    output replica_data_t ordering_min_data,
    output total_data_t   best_distance
);

    logic          run_update;
    logic          update_d;
    logic          write_valid;
    city_t         wcount;
    city_t         rcount;
    total_data_t   in_distance;
    total_data_t   min_distance;
    replica_data_t ram [0:`CITY_COUNT-1];

    ////////////////////////////////////////////////////////////////////////////
    // distance compare
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            update_d     <= 1'b0;
            run_update   <= 1'b0;
            wcount       <= '0;
            min_distance <= '1; // anything beats this.
        end else begin
            update_d <= update_minimum_distance;
            if (update_minimum_distance) begin
                run_update <= 1'b1;
                wcount     <= '0;
            end else if (update_d) begin
                if (in_distance < min_distance) begin
                    min_distance <= in_distance;
                end else begin
                    run_update <= 1'b0; // ties keep the old ordering.
                end
            end else if (write_valid) begin
                wcount <= wcount + city_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (update_minimum_distance) begin
            in_distance <= minimum_distance;
        end
    end

    assign write_valid   = replay_valid && run_update;
    assign best_distance = min_distance;

    ////////////////////////////////////////////////////////////////////////////
    // ordering store and readout
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            rcount             <= '0;
            ordering_min_valid <= 1'b0;
        end else begin
            ordering_min_valid <= min_ord_read;
            if (read_restart) begin
                rcount <= '0;
            end else if (min_ord_read) begin
                rcount <= rcount + city_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_valid) begin
            ram[wcount] <= replay_data;
        end
        ordering_min_data <= ram[rcount];
    end

endmodule

`default_nettype wire

// ==== logic/tour_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "replica_consts.svh"

module tour_buffer
    import replica_pkg::*;
(
    input  logic          clk,
    input  logic          load_accept,
    input  city_t         tour_city,
    input  city_t         city_idx,
    output replica_data_t replay_data
);

    replica_data_t tour_mem [0:`CITY_COUNT-1];

    // entry n holds the n-th city of the tour.
    always_ff @(posedge clk) begin
        if (load_accept) begin
            tour_mem[city_idx] <= replica_data_t'(tour_city);
        end
    end

    // replay walks the same index, so order is kept.
    assign replay_data = tour_mem[city_idx];

endmodule

`default_nettype wire

// ==== logic/tour_length_accum.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "replica_consts.svh"

module tour_length_accum
    import replica_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        coord_wr,
    input  city_t       coord_addr,
    input  coord_t      coord_x,
    input  coord_t      coord_y,
    input  logic        load_accept,
    input  city_t       tour_city,
    input  city_t       city_idx,
    input  logic        last_city,
    output total_data_t tour_distance
);

    coord_t      x_table [0:`CITY_COUNT-1];
    coord_t      y_table [0:`CITY_COUNT-1];
    city_t       first_city;
    city_t       prev_city;
    total_data_t step_len;
    total_data_t close_len;
    total_data_t sum_q;

    ////////////////////////////////////////////////////////////////////////////
    // coordinate table
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (coord_wr) begin
            x_table[coord_addr] <= coord_x;
            y_table[coord_addr] <= coord_y;
        end
    end

    // manhattan distance between two cities.
    function automatic total_data_t leg_length(input city_t a, input city_t b);
        coord_t dx;
        coord_t dy;
        dx = (x_table[a] > x_table[b]) ? x_table[a] - x_table[b] : x_table[b] - x_table[a];
        dy = (y_table[a] > y_table[b]) ? y_table[a] - y_table[b] : y_table[b] - y_table[a];
        leg_length = total_data_t'(dx) + total_data_t'(dy);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // leg adder
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        step_len  = leg_length(tour_city, prev_city);
        close_len = last_city ? leg_length(tour_city, first_city) : '0; // back to start.
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sum_q <= '0;
        end else if (load_accept) begin
            if (city_idx == '0) begin
                sum_q <= '0; // first city has no leg.
            end else begin
                sum_q <= sum_q + step_len + close_len;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_accept) begin
            if (city_idx == '0) begin
                first_city <= tour_city;
            end
            prev_city <= tour_city;
        end
    end

    assign tour_distance = sum_q;

endmodule

`default_nettype wire

// ==== logic/tour_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tour_sequencer
    import replica_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic tour_valid,
    output logic tour_ready,
    input  logic last_city,
    output logic count_en,
    output logic count_clear,
    output logic load_accept,
    output logic update_strobe,
    output logic replay_valid,
    output logic tour_distance_valid
);

    tour_state_t state;
    tour_state_t state_next;

    ////////////////////////////////////////////////////////////////////////////
    // state register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_LOAD;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            S_LOAD: begin
                if (load_accept && last_city) begin
                    state_next = S_UPDATE;
                end
            end
            S_UPDATE: state_next = S_DECIDE;
            S_DECIDE: state_next = S_REPLAY;
            S_REPLAY: begin
                if (last_city) begin
                    state_next = S_LOAD;
                end
            end
            default: state_next = S_LOAD;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////////////////////

    assign tour_ready  = (state == S_LOAD);
    assign load_accept = tour_valid && tour_ready;

    assign update_strobe       = (state == S_UPDATE);
    assign tour_distance_valid = (state == S_UPDATE); // one cycle only.
    assign replay_valid        = (state == S_REPLAY);

    // step on every accepted city and every replay beat.
    assign count_en = load_accept || replay_valid;

    // rewind the counter whenever the phase changes.
    assign count_clear = (state_next != state);

endmodule

`default_nettype wire

// ==== logic/city_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "replica_consts.svh"

module city_counter
    import replica_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  count_en,
    input  logic  count_clear,
    output city_t city_idx,
    output logic  last_city
);

    localparam city_t LAST_IDX = city_t'(`CITY_COUNT - 1);

    city_t idx_q;

    // clear wins over a step.
    always_ff @(posedge clk) begin
        if (reset) begin
            idx_q <= '0;
        end else if (count_clear) begin
            idx_q <= '0;
        end else if (count_en) begin
            idx_q <= idx_q + city_t'(1); // wraps after the last city.
        end
    end

    assign city_idx  = idx_q;
    assign last_city = (idx_q == LAST_IDX);

endmodule

`default_nettype wire

// ==== logic/replica_pkg.sv ====
`default_nettype none

`include "replica_consts.svh"

package replica_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // vector types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [`CITY_DIV_LOG-1:0] city_t;         // index into the city table.
    typedef logic [`CITY_DIV_LOG-1:0] replica_data_t; // one ordering entry.
    typedef logic [`COORD_BITS-1:0]   coord_t;        // x or y.
    typedef logic [`TOTAL_BITS-1:0]   total_data_t;   // closed tour length.

    ////////////////////////////////////////////////////////////////////////////
    // sequencer states
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        S_LOAD   = 2'd0,  // accepting cities.
        S_UPDATE = 2'd1,  // distance final.
        S_DECIDE = 2'd2,  // keeper compares.
        S_REPLAY = 2'd3   // ordering streamed out.
    } tour_state_t;

endpackage

`default_nettype wire

// ==== logic/replica_consts.svh ====
`ifndef REPLICA_CONSTS_SVH
`define REPLICA_CONSTS_SVH

// tour geometry.
`define CITY_DIV_LOG 3
`define CITY_COUNT   (1 << `CITY_DIV_LOG)

// coordinate grid.
`define COORD_BITS   8

// tour length width.
`define TOTAL_BITS   16

`endif
